//--- design/correlator_defines.svh
// ==============================
// Correlator parameters
// Input, lag, counter and integration
// sizes shared by all blocks.
// ==============================

`ifndef CORRELATOR_DEFINES_SVH
`define CORRELATOR_DEFINES_SVH

// Number of one-bit signal inputs.
`define CORR_NUM_INPUTS 4

// One-sided lag count, taps 0 .. CORR_LAG-1 per delay line.
`define CORR_LAG 2

// Lag points per baseline, from -(CORR_LAG-1) to +(CORR_LAG-1).
`define CORR_LAG_TAPS (2 * `CORR_LAG - 1)

// Input pairs i<j.
`define CORR_NUM_BASELINES (`CORR_NUM_INPUTS * (`CORR_NUM_INPUTS - 1) / 2)

// Agreement counter width.
`define CORR_RESOLUTION 16

// Samples per integration.
`define CORR_INTEG_LEN 64

// Words sent per frame.
`define CORR_FRAME_WORDS (`CORR_NUM_BASELINES * `CORR_LAG_TAPS)

`endif

//--- design/correlator_pkg.sv
// ==============================
// Correlator types
// Samples, counts, indices and the
// tagged readout word.
// ==============================

`include "correlator_defines.svh"

package correlator_pkg;

	// One sample from every input.
	typedef logic [`CORR_NUM_INPUTS-1:0] sample_t;

	// Delay-line history of one input, tap 0 newest.
	typedef logic [`CORR_LAG-1:0] taps_t;

	typedef logic [`CORR_RESOLUTION-1:0] count_t;

	// All lag totals of one baseline.
	typedef count_t [`CORR_LAG_TAPS-1:0] lag_counts_t;

	// Integration sequence number, wraps.
	typedef logic [7:0] frame_idx_t;

	typedef logic [2:0] baseline_t;

	// Index 0 is the most negative lag.
	typedef logic [1:0] lag_idx_t;

	typedef struct packed {
		frame_idx_t frame_idx;
		baseline_t  baseline;
		lag_idx_t   lag;
		count_t     count;
	} corr_word_t;

	typedef enum logic [1:0] {
		idle,
		present,
		wait_ack_low
	} readout_state_t;

endpackage

//--- design/sample_delay_line.sv
// ==============================
// Sample delay line
// Keeps the last CORR_LAG samples
// of one input as lagged taps.
// ==============================

`include "correlator_defines.svh"

module sample_delay_line
	import correlator_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  strobe,
	input  logic  sample,
	output taps_t taps
);

	taps_t shift_next;

	// New sample enters at tap 0, oldest falls off the top.
	always_comb begin
		shift_next = taps << 1;
		shift_next[0] = sample;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			taps <= '0;
		end else if (strobe) begin
			taps <= shift_next;
		end
	end

endmodule

//--- design/baseline_accumulator.sv
// ==============================
// Baseline accumulator
// Counts sample agreements of one
// input pair at every lag.
// ==============================

`include "correlator_defines.svh"

module baseline_accumulator
	import correlator_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        step,
	input  logic        dump,
	input  taps_t       taps_a,
	input  taps_t       taps_b,
	output lag_counts_t totals
);

	logic [`CORR_LAG_TAPS-1:0] agree;
	lag_counts_t running;

	genvar k;
	generate
		for (k = 0; k < `CORR_LAG_TAPS; k++) begin : g_lag
			localparam int lag = k - (`CORR_LAG - 1);

			// Positive lag delays input b, negative lag delays input a.
			if (lag >= 0) begin : g_pos
				assign agree[k] = (taps_a[0] == taps_b[lag]);
			end else begin : g_neg
				assign agree[k] = (taps_a[-lag] == taps_b[0]);
			end

			// Counter must not wrap inside an integration.
			no_overflow: assert property (
				@(posedge clk) disable iff (!reset)
				step |-> running[k] != '1
			);
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!reset) begin
			running <= '0;
			totals <= '0;
		end else if (step) begin
			for (int i = 0; i < `CORR_LAG_TAPS; i++) begin
				if (dump) begin
					// Last step of the frame goes into the dump.
					totals[i] <= running[i] + count_t'(agree[i]);
					running[i] <= '0;
				end else begin
					running[i] <= running[i] + count_t'(agree[i]);
				end
			end
		end
	end

endmodule

//--- design/integration_control.sv
// ==============================
// Integration control
// Turns strobes into accumulate steps
// and closes a frame every
// CORR_INTEG_LEN samples.
// ==============================

`include "correlator_defines.svh"

module integration_control
	import correlator_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       sample_strobe,
	output logic       step,
	output logic       dump,
	output logic       frame_ready,
	output frame_idx_t frame_idx
);

	localparam int cnt_w = $clog2(`CORR_INTEG_LEN);

	logic [cnt_w-1:0] step_cnt;

	// Dump rides on the last step of the integration.
	assign dump = step && (step_cnt == cnt_w'(`CORR_INTEG_LEN - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			step <= 1'b0;
			step_cnt <= '0;
			frame_ready <= 1'b0;
			frame_idx <= '0;
		end else begin
			step <= sample_strobe;
			frame_ready <= dump;
			if (step) begin
				step_cnt <= dump ? '0 : step_cnt + 1'b1;
			end
			// Index moves on once the frame has been offered.
			if (frame_ready) begin
				frame_idx <= frame_idx + 1'b1;
			end
		end
	end

	// A dump only follows a real strobe.
	dump_needs_step: assert property (
		@(posedge clk) disable iff (!reset)
		dump |-> step && $past(sample_strobe)
	);

endmodule

//--- design/frame_readout.sv
// ==============================
// Frame readout
// Captures a dumped frame and sends
// it word by word over req/ack.
// ==============================

`include "correlator_defines.svh"

module frame_readout
	import correlator_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        frame_ready,
	input  frame_idx_t  frame_idx,
	input  lag_counts_t totals [`CORR_NUM_BASELINES],
	output corr_word_t  out_word,
	output logic        out_req,
	input  logic        out_ack,
	output logic        frame_dropped
);

	readout_state_t state;
	lag_counts_t frame_buf [`CORR_NUM_BASELINES];
	frame_idx_t frame_idx_q;
	baseline_t bl;
	lag_idx_t lag;
	logic last_word;

	assign last_word = (bl == baseline_t'(`CORR_NUM_BASELINES - 1)) &&
		(lag == lag_idx_t'(`CORR_LAG_TAPS - 1));

	assign out_req = (state == present);
	assign out_word = '{
		frame_idx: frame_idx_q,
		baseline:  bl,
		lag:       lag,
		count:     frame_buf[bl][lag]
	};

	// Capture of a dumped frame while idle.
	always_ff @(posedge clk) begin
		if (state == idle && frame_ready) begin
			frame_buf <= totals;
			frame_idx_q <= frame_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			bl <= '0;
			lag <= '0;
			frame_dropped <= 1'b0;
		end else begin
			frame_dropped <= frame_ready && (state != idle);
			case (state)
				idle: begin
					if (frame_ready) begin
						bl <= '0;
						lag <= '0;
						state <= present;
					end
				end
				present: begin
					if (out_ack) state <= wait_ack_low;
				end
				wait_ack_low: begin
					// Next word only after the consumer released ack.
					if (!out_ack) begin
						if (last_word) begin
							state <= idle;
						end else begin
							if (lag == lag_idx_t'(`CORR_LAG_TAPS - 1)) begin
								lag <= '0;
								bl <= bl + 1'b1;
							end else begin
								lag <= lag + 1'b1;
							end
							state <= present;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	word_stable: assert property (
		@(posedge clk) disable iff (!reset)
		out_req && $past(out_req) |-> $stable(out_word)
	);

endmodule

//--- design/correlator_top.sv
// ==============================
// Lag correlator top
// Four one-bit inputs, six baselines,
// framed req/ack readout.
// ==============================

`include "correlator_defines.svh"

module correlator_top
	import correlator_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       sample_strobe,
	input  sample_t    sample,
	output corr_word_t out_word,
	output logic       out_req,
	input  logic       out_ack,
	output logic       frame_dropped
);

	taps_t taps [`CORR_NUM_INPUTS];
	lag_counts_t totals [`CORR_NUM_BASELINES];
	logic step;
	logic dump;
	logic frame_ready;
	frame_idx_t frame_idx;

	genvar i, j;
	generate
		for (i = 0; i < `CORR_NUM_INPUTS; i++) begin : g_line
			sample_delay_line u_delay (
				.clk    (clk),
				.reset  (reset),
				.strobe (sample_strobe),
				.sample (sample[i]),
				.taps   (taps[i])
			);
		end

		// Baselines numbered (0,1), (0,2), (0,3), (1,2), (1,3), (2,3).
		for (i = 0; i < `CORR_NUM_INPUTS - 1; i++) begin : g_a
			for (j = i + 1; j < `CORR_NUM_INPUTS; j++) begin : g_b
				localparam int bl = i * `CORR_NUM_INPUTS - i * (i + 1) / 2 + (j - i - 1);

				baseline_accumulator u_acc (
					.clk    (clk),
					.reset  (reset),
					.step   (step),
					.dump   (dump),
					.taps_a (taps[i]),
					.taps_b (taps[j]),
					.totals (totals[bl])
				);
			end
		end
	endgenerate

	integration_control u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.step          (step),
		.dump          (dump),
		.frame_ready   (frame_ready),
		.frame_idx     (frame_idx)
	);

	frame_readout u_readout (
		.clk           (clk),
		.reset         (reset),
		.frame_ready   (frame_ready),
		.frame_idx     (frame_idx),
		.totals        (totals),
		.out_word      (out_word),
		.out_req       (out_req),
		.out_ack       (out_ack),
		.frame_dropped (frame_dropped)
	);

endmodule

//--- tb/correlator_tb.sv
// ==============================
// Correlator testbench
// Random samples against a reference
// model, with a req/ack responder.
// ==============================

`include "correlator_defines.svh"

module correlator_tb
	import correlator_pkg::*;
();

	logic clk;
	logic reset;
	logic sample_strobe;
	sample_t sample;
	corr_word_t out_word;
	logic out_req;
	logic out_ack;
	logic frame_dropped;

	integer seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int ack_max;
	// Reference model.
	taps_t m_taps [`CORR_NUM_INPUTS];
	count_t run_count [`CORR_NUM_BASELINES][`CORR_LAG_TAPS];
	count_t exp_count [256][`CORR_NUM_BASELINES][`CORR_LAG_TAPS];
	int m_steps;
	frame_idx_t m_frame;
	int m_total;
	// Readout tracking.
	int word_pos;
	frame_idx_t expect_frame;
	frame_idx_t cur_frame;
	int frames_done;
	int drops;
	logic prev_req;
	logic prev_ack;
	corr_word_t prev_word;

	correlator_top uut (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.out_word      (out_word),
		.out_req       (out_req),
		.out_ack       (out_ack),
		.frame_dropped (frame_dropped)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("Simulation failed");
		$finish;
	endtask

	function automatic int pick_delay(input int max_delay);
		if (max_delay == 0) return 0;
		return $unsigned($random(seed)) % (max_delay + 1);
	endfunction

	// Model and trackers restart with the DUT.
	task automatic apply_reset(input int cycles);
		reset = 1'b0;
		sample_strobe = 1'b0;
		repeat (cycles) @(negedge clk);
		for (int n = 0; n < `CORR_NUM_INPUTS; n++) m_taps[n] = '0;
		for (int b = 0; b < `CORR_NUM_BASELINES; b++)
			for (int k = 0; k < `CORR_LAG_TAPS; k++) run_count[b][k] = '0;
		m_steps = 0;
		m_frame = '0;
		m_total = 0;
		word_pos = 0;
		expect_frame = '0;
		frames_done = 0;
		drops = 0;
		reset = 1'b1;
	endtask

	task automatic push_sample(input sample_t s, input int gap);
		int bl;
		int lag;
		logic bit_a;
		logic bit_b;
		@(negedge clk);
		sample = s;
		sample_strobe = 1'b1;
		for (int n = 0; n < `CORR_NUM_INPUTS; n++)
			m_taps[n] = taps_t'(m_taps[n] << 1) | taps_t'(s[n]);
		bl = 0;
		for (int a = 0; a < `CORR_NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < `CORR_NUM_INPUTS; b++) begin
				for (int k = 0; k < `CORR_LAG_TAPS; k++) begin
					lag = k - (`CORR_LAG - 1);
					bit_a = (lag >= 0) ? m_taps[a][0] : m_taps[a][-lag];
					bit_b = (lag >= 0) ? m_taps[b][lag] : m_taps[b][0];
					if (bit_a == bit_b) run_count[bl][k]++;
				end
				bl++;
			end
		end
		m_steps++;
		if (m_steps == `CORR_INTEG_LEN) begin
			for (int b = 0; b < `CORR_NUM_BASELINES; b++) begin
				for (int k = 0; k < `CORR_LAG_TAPS; k++) begin
					exp_count[m_frame][b][k] = run_count[b][k];
					run_count[b][k] = '0;
				end
			end
			m_steps = 0;
			m_frame++;
			m_total++;
		end
		repeat (gap) begin
			@(negedge clk);
			sample_strobe = 1'b0;
		end
	endtask

	task automatic wait_frames(input int limit);
		int cycles;
		cycles = 0;
		// End the last strobe of the burst.
		@(negedge clk);
		sample_strobe = 1'b0;
		while (frames_done + drops < m_total) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) abort_run("readout did not deliver all frames in time");
		end
	endtask

	// Checks one word, then runs the four-phase handshake for it.
	task automatic serve_word();
		int cycles;
		int bl;
		int lag;
		if (word_pos == 0) begin
			check_value("out_word.frame_idx (sequence)", out_word.frame_idx, expect_frame);
			cur_frame = out_word.frame_idx;
			expect_frame = out_word.frame_idx + 1'b1;
		end
		bl = word_pos / `CORR_LAG_TAPS;
		lag = word_pos % `CORR_LAG_TAPS;
		check_value("out_word.frame_idx", out_word.frame_idx, cur_frame);
		check_value("out_word.baseline", out_word.baseline, bl);
		check_value("out_word.lag", out_word.lag, lag);
		check_value("out_word.count", out_word.count, exp_count[cur_frame][bl][lag]);
		word_pos++;
		if (word_pos == `CORR_FRAME_WORDS) begin
			word_pos = 0;
			frames_done++;
		end
		repeat (pick_delay(ack_max)) @(negedge clk);
		out_ack = 1'b1;
		cycles = 0;
		while (out_req) begin
			@(negedge clk);
			cycles++;
			if (cycles > 50) abort_run("out_req stayed high after out_ack");
		end
		repeat (pick_delay(ack_max)) @(negedge clk);
		out_ack = 1'b0;
	endtask

	always @(negedge clk) begin
		if (reset && out_req && !out_ack) serve_word();
	end

	// A dropped frame index is skipped by the next received frame.
	always @(negedge clk) begin
		if (reset && frame_dropped) begin
			drops++;
			expect_frame++;
		end
	end

	always @(posedge clk) begin
		if (reset && out_req && !prev_req) check_value("out_ack at out_req rise", prev_ack, 0);
		if (reset && out_req && prev_req) check_value("out_word", out_word, prev_word);
		prev_req = out_req;
		prev_ack = out_ack;
		prev_word = out_word;
	end

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial begin
		int err_before;
		seed = 9;
		clk = 1'b0;
		sample = '0;
		out_ack = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		ack_max = 0;
		prev_req = 1'b0;
		prev_ack = 1'b0;
		prev_word = '0;
		apply_reset(16);

		err_before = errors;
		repeat (`CORR_INTEG_LEN) push_sample('1, 0);
		wait_frames(4000);
		report_test("constant ones", err_before);

		err_before = errors;
		repeat (4 * `CORR_INTEG_LEN) push_sample(sample_t'($random(seed)), 0);
		wait_frames(8000);
		check_value("frame_dropped count", drops, 0);
		report_test("random back-to-back, fast ack", err_before);

		err_before = errors;
		ack_max = 2;
		repeat (2 * `CORR_INTEG_LEN) push_sample(sample_t'($random(seed)), 1);
		wait_frames(8000);
		report_test("word order and tags", err_before);

		err_before = errors;
		ack_max = 8;
		repeat (4 * `CORR_INTEG_LEN)
			push_sample(sample_t'($random(seed)), $unsigned($random(seed)) % 4);
		wait_frames(20000);
		report_test("random gaps and ack delays", err_before);

		err_before = errors;
		ack_max = 3;
		repeat (2 * `CORR_INTEG_LEN)
			push_sample(sample_t'($random(seed)), $unsigned($random(seed)) % 2);
		wait_frames(10000);
		report_test("handshake protocol", err_before);

		err_before = errors;
		ack_max = 4;
		repeat (100) push_sample(sample_t'($random(seed)), 0);
		apply_reset(4);
		check_value("out_req", out_req, 0);
		repeat (`CORR_INTEG_LEN) push_sample(sample_t'($random(seed)), 0);
		wait_frames(4000);
		check_value("frames after reset", frames_done, 1);
		report_test("reset mid-frame", err_before);

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+design
design/correlator_pkg.sv
design/sample_delay_line.sv
design/baseline_accumulator.sv
design/integration_control.sv
design/frame_readout.sv
design/correlator_top.sv
tb/correlator_tb.sv

//--- Bender.yml
package:
  name: correlator

sources:
  - include_dirs:
      - design
    files:
      - design/correlator_pkg.sv
      - design/sample_delay_line.sv
      - design/baseline_accumulator.sv
      - design/integration_control.sv
      - design/frame_readout.sv
      - design/correlator_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/correlator_tb.sv
